// ==== src/conv_data_pkg.sv ====
package conv_data_pkg;

  //////////////////////////////
  // Word widths
  //////////////////////////////

  localparam int DATA_WIDTH    = 16;
  localparam int PRODUCT_WIDTH = 2 * DATA_WIDTH;

  // Q8.8 signed fixed point
  localparam int FRAC_BITS = 8;

  //////////////////////////////
  // Data types
  //////////////////////////////

  // Pixel, partial sum or result word
  typedef logic signed [DATA_WIDTH-1:0] data_t;

  // Filter weight, same format as the data
  typedef logic signed [DATA_WIDTH-1:0] weight_t;

  // Full-width product before scaling back to Q8.8
  typedef logic signed [PRODUCT_WIDTH-1:0] product_t;

endpackage

// ==== src/conv_geom_pkg.sv ====
package conv_geom_pkg;

  //////////////////////////////
  // Layer geometry
  //////////////////////////////

  localparam int IMAGE_WIDTH     = 4;
  localparam int IMAGE_HEIGHT    = 4;
  localparam int IMAGE_SIZE      = IMAGE_WIDTH * IMAGE_HEIGHT;
  localparam int CHANNEL_NUM_IN  = 4;
  localparam int CHANNEL_NUM_OUT = 2;

  // One weight per (output, input) channel pair
  localparam int WEIGHT_NUM = CHANNEL_NUM_IN * CHANNEL_NUM_OUT;

  // Words replayed for every stored pixel
  localparam int REPLAY_LEN = CHANNEL_NUM_IN * CHANNEL_NUM_OUT;

  localparam int FIFO_DEPTH = 8;

  //////////////////////////////
  // Counter widths
  //////////////////////////////

  typedef logic [1:0] chan_in_idx_t;
  typedef logic       chan_out_idx_t;
  typedef logic [2:0] weight_idx_t;
  typedef logic [2:0] fifo_ptr_t;

  typedef enum logic {IDLE, REPLAY} loop_state_t;

endpackage

// ==== src/conv_loop_data.sv ====
`timescale 1ns/1ps

module conv_loop_data
  import conv_data_pkg::*, conv_geom_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  valid_in,
  input  data_t pxl_in,
  output data_t pxl_out,
  output logic  valid_out,
  output logic  first_out
);

  // Two pixel halves, one filling while the other replays
  data_t pxl_buf [2][CHANNEL_NUM_IN];

  logic          wr_half;
  chan_in_idx_t  wr_idx;
  logic          rd_half;
  chan_in_idx_t  rd_in;
  chan_out_idx_t rd_out;
  loop_state_t   state;

  logic pxl_done;
  logic replay_last;

  assign pxl_done    = valid_in && (wr_idx == chan_in_idx_t'(CHANNEL_NUM_IN - 1));
  assign replay_last = (rd_in == chan_in_idx_t'(CHANNEL_NUM_IN - 1)) &&
                       (rd_out == chan_out_idx_t'(CHANNEL_NUM_OUT - 1));

  //////////////////////////////
  // Write side
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (valid_in) begin
      pxl_buf[wr_half][wr_idx] <= pxl_in;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_half <= 1'b0;
      wr_idx  <= '0;
    end else if (valid_in) begin
      wr_idx <= wr_idx + 1'b1;
      // Swap halves once all input channels are in
      if (pxl_done) begin
        wr_half <= ~wr_half;
      end
    end
  end

  //////////////////////////////
  // Replay FSM
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= IDLE;
      rd_half <= 1'b0;
      rd_in   <= '0;
      rd_out  <= '0;
    end else if (pxl_done) begin
      // New pixel complete, replay the half just filled
      state   <= REPLAY;
      rd_half <= wr_half;
      rd_in   <= '0;
      rd_out  <= '0;
    end else if (state == REPLAY) begin
      rd_in <= rd_in + 1'b1;
      if (rd_in == chan_in_idx_t'(CHANNEL_NUM_IN - 1)) begin
        rd_out <= rd_out + 1'b1;
      end
      if (replay_last) begin
        state <= IDLE;
      end
    end
  end

  assign pxl_out   = pxl_buf[rd_half][rd_in];
  assign valid_out = (state == REPLAY);
  assign first_out = (state == REPLAY) && (rd_in == '0);

endmodule

// ==== src/conv_weight_mac.sv ====
`timescale 1ns/1ps

module conv_weight_mac
  import conv_data_pkg::*, conv_geom_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    valid_weight_in,
  input  weight_t weight_in,
  input  logic    valid_in,
  input  logic    first_in,
  input  data_t   pxl_in,
  output data_t   prod_out,
  output logic    valid_out,
  output logic    first_out
);

  // Output channel major, input channel minor
  weight_t weight_mem [WEIGHT_NUM];

  weight_idx_t load_idx;
  weight_idx_t rd_idx;
  product_t    prod;

  //////////////////////////////
  // Serial weight load
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (valid_weight_in) begin
      weight_mem[load_idx] <= weight_in;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      load_idx <= '0;
    end else if (valid_weight_in) begin
      if (load_idx == weight_idx_t'(WEIGHT_NUM - 1)) begin
        load_idx <= '0;
      end else begin
        load_idx <= load_idx + 1'b1;
      end
    end
  end

  //////////////////////////////
  // Multiply
  //////////////////////////////

  // Read index follows the replayed stream word for word
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_idx <= '0;
    end else if (valid_in) begin
      if (rd_idx == weight_idx_t'(WEIGHT_NUM - 1)) begin
        rd_idx <= '0;
      end else begin
        rd_idx <= rd_idx + 1'b1;
      end
    end
  end

  assign prod = product_t'(pxl_in) * product_t'(weight_mem[rd_idx]);

  // Arithmetic shift back to Q8.8, upper bits dropped
  always_ff @(posedge clk) begin
    prod_out <= data_t'(prod >>> FRAC_BITS);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out <= 1'b0;
      first_out <= 1'b0;
    end else begin
      valid_out <= valid_in;
      first_out <= valid_in && first_in;
    end
  end

endmodule

// ==== src/conv_channel_adder.sv ====
`timescale 1ns/1ps

module conv_channel_adder
  import conv_data_pkg::*, conv_geom_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  valid_in,
  input  logic  first_in,
  input  data_t pxl_in,
  output data_t pxl_out,
  output logic  valid_out
);

  data_t        acc;
  data_t        acc_next;
  chan_in_idx_t cnt;
  chan_in_idx_t ch_idx;
  logic         last_ch;

  // Group marker restarts both the count and the sum
  assign ch_idx   = first_in ? '0 : cnt;
  assign acc_next = first_in ? pxl_in : data_t'(acc + pxl_in);
  assign last_ch  = valid_in && (ch_idx == chan_in_idx_t'(CHANNEL_NUM_IN - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt <= '0;
    end else if (valid_in) begin
      cnt <= ch_idx + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_in) begin
      acc <= acc_next;
    end
    if (last_ch) begin
      pxl_out <= acc_next;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= last_ch;
    end
  end

endmodule

// ==== src/conv_align_fifo.sv ====
`timescale 1ns/1ps

module conv_align_fifo
  import conv_data_pkg::*, conv_geom_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  wr_en,
  input  data_t din,
  output data_t dout,
  output logic  valid_out
);

  data_t mem [FIFO_DEPTH];

  fifo_ptr_t                  wr_ptr;
  fifo_ptr_t                  rd_ptr;
  logic [$clog2(FIFO_DEPTH):0] count;
  logic                       full;
  logic                       empty;
  logic                       read_en;
  logic                       wr;
  logic                       rd;

  assign full  = (count == FIFO_DEPTH);
  assign empty = (count == '0);
  assign rd    = read_en && !empty;
  assign wr    = wr_en && (!full || rd);

  //////////////////////////////
  // Storage and pointers
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wr_ptr] <= din;
    end
    if (rd) begin
      dout <= mem[rd_ptr];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr) wr_ptr <= wr_ptr + 1'b1;
      if (rd) rd_ptr <= rd_ptr + 1'b1;
      count <= count + wr - rd;
    end
  end

  //////////////////////////////
  // Read enable and output valid
  //////////////////////////////

  // Sticky after the first fill so the output stays dense
  always_ff @(posedge clk) begin
    if (reset) begin
      read_en   <= 1'b0;
      valid_out <= 1'b0;
    end else begin
      if (full) read_en <= 1'b1;
      valid_out <= rd;
    end
  end

endmodule

// ==== src/conv_1x1_layer.sv ====
`timescale 1ns/1ps

module conv_1x1_layer
  import conv_data_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    valid_in,
  input  data_t   pxl_in,
  input  logic    valid_weight_in,
  input  weight_t weight_in,
  output data_t   pxl_out,
  output logic    valid_out
);

  data_t loop_pxl;
  logic  loop_valid;
  logic  loop_first;
  data_t prod_data;
  logic  prod_valid;
  logic  prod_first;
  data_t sum_data;
  logic  sum_valid;

  // Store one pixel and replay it per output channel
  conv_loop_data conv_loop_data_i (
    .clk       (clk),
    .reset     (reset),
    .valid_in  (valid_in),
    .pxl_in    (pxl_in),
    .pxl_out   (loop_pxl),
    .valid_out (loop_valid),
    .first_out (loop_first)
  );

  conv_weight_mac conv_weight_mac_i (
    .clk             (clk),
    .reset           (reset),
    .valid_weight_in (valid_weight_in),
    .weight_in       (weight_in),
    .valid_in        (loop_valid),
    .first_in        (loop_first),
    .pxl_in          (loop_pxl),
    .prod_out        (prod_data),
    .valid_out       (prod_valid),
    .first_out       (prod_first)
  );

  // Sum over input channels
  conv_channel_adder conv_channel_adder_i (
    .clk       (clk),
    .reset     (reset),
    .valid_in  (prod_valid),
    .first_in  (prod_first),
    .pxl_in    (prod_data),
    .pxl_out   (sum_data),
    .valid_out (sum_valid)
  );

  conv_align_fifo conv_align_fifo_i (
    .clk       (clk),
    .reset     (reset),
    .wr_en     (sum_valid),
    .din       (sum_data),
    .dout      (pxl_out),
    .valid_out (valid_out)
  );

endmodule

// ==== tests/conv_ref_model.svh ====
`ifndef CONV_REF_MODEL_SVH
`define CONV_REF_MODEL_SVH

// One input channel term, Q8.8 product shifted back and cut to 16 bits
function automatic data_t scaled_product(data_t pxl, weight_t w);
  int full;
  full = int'(pxl) * int'(w);
  return data_t'(full >>> FRAC_BITS);
endfunction

// Expected result word of one output channel for one pixel
function automatic data_t expected_word(data_t pxl [CHANNEL_NUM_IN],
                                        weight_t w [WEIGHT_NUM], int oc);
  data_t sum;
  sum = '0;
  for (int ic = 0; ic < CHANNEL_NUM_IN; ic++) begin
    // Sum wraps at 16 bits
    sum = data_t'(sum + scaled_product(pxl[ic], w[oc * CHANNEL_NUM_IN + ic]));
  end
  return sum;
endfunction

`endif

// ==== tests/conv_1x1_layer_tb.sv ====
`timescale 1ns/1ps

module conv_1x1_layer_tb
  import conv_data_pkg::*, conv_geom_pkg::*;
();

  localparam int CLK_PERIOD      = 20;
  localparam int RESET_CYCLES    = 10;
  localparam int PIXEL_SPACING   = REPLAY_LEN + 3;
  localparam int RESULTS_PER_RUN = IMAGE_SIZE * CHANNEL_NUM_OUT;
  localparam int TIMEOUT_CYCLES  = 2 * (IMAGE_SIZE * (REPLAY_LEN + 7) + 100);

  logic    clk;
  logic    reset;
  logic    valid_in;
  data_t   pxl_in;
  logic    valid_weight_in;
  weight_t weight_in;
  data_t   pxl_out;
  logic    valid_out;

  weight_t weights [WEIGHT_NUM];
  data_t   expected_q [$];
  int      pixels_sent;
  int      run_outputs;
  int      cycle_count;

  `include "conv_ref_model.svh"

  conv_1x1_layer conv_1x1_layer_i (
    .clk             (clk),
    .reset           (reset),
    .valid_in        (valid_in),
    .pxl_in          (pxl_in),
    .valid_weight_in (valid_weight_in),
    .weight_in       (weight_in),
    .pxl_out         (pxl_out),
    .valid_out       (valid_out)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic report_mismatch(string msg);
    fail_run($sformatf("CHECK FAILED at %0t: %s", $time, msg));
  endtask

  //////////////////////////////
  // Scoreboard and assertions
  //////////////////////////////

  // DUT outputs sampled before this edge updates them
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      fail_run("Timeout: the runs did not finish within the cycle limit");
    end else if (reset) begin
      run_outputs = 0;
    end else if (valid_out) begin
      // Words beyond the expected ones only raise the count
      if (expected_q.size() > 0) begin
        assert (pxl_out == expected_q[0])
          else report_mismatch($sformatf("word %0d is %h, expected %h (%0d left)",
                                         run_outputs, pxl_out, expected_q[0],
                                         expected_q.size()));
        void'(expected_q.pop_front());
      end
      run_outputs++;
    end
  end

  assert property (@(posedge clk) reset |=> !valid_out)
    else report_mismatch("valid_out asserted during reset");

  // Nothing leaves before four full pixels could fill the FIFO
  assert property (@(posedge clk) disable iff (reset)
    valid_out |-> pixels_sent >= FIFO_DEPTH / CHANNEL_NUM_OUT)
    else report_mismatch("valid_out before the FIFO could have filled");

  // The first FIFO_DEPTH words of a run leave back to back
  assert property (@(posedge clk) disable iff (reset)
    (valid_out && run_outputs < FIFO_DEPTH - 1) |=> valid_out)
    else report_mismatch("gap in the output stream during the first drain");

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic load_weights();
    for (int i = 0; i < WEIGHT_NUM; i++) begin
      weights[i] = weight_t'($urandom);
      @(negedge clk);
      valid_weight_in = 1'b1;
      weight_in       = weights[i];
    end
    @(negedge clk);
    valid_weight_in = 1'b0;
  endtask

  task automatic send_pixel();
    data_t pxl [CHANNEL_NUM_IN];
    int    gap;
    gap = $urandom_range(4, 0);
    for (int ic = 0; ic < CHANNEL_NUM_IN; ic++) begin
      pxl[ic] = data_t'($urandom);
      @(negedge clk);
      valid_in = 1'b1;
      pxl_in   = pxl[ic];
    end
    @(negedge clk);
    valid_in = 1'b0;
    pixels_sent++;
    for (int oc = 0; oc < CHANNEL_NUM_OUT; oc++) begin
      expected_q.push_back(expected_word(pxl, weights, oc));
    end
    // First words of two pixels are PIXEL_SPACING + gap cycles apart
    repeat (PIXEL_SPACING - CHANNEL_NUM_IN - 1 + gap) @(negedge clk);
  endtask

  // Stray weights and one pixel and a word, so the next reset hits
  // the load index, write index and replay mid-way
  task automatic leave_counters_midway();
    for (int i = 0; i < CHANNEL_NUM_IN + 1; i++) begin
      @(negedge clk);
      valid_weight_in = 1'b1;
      weight_in       = weight_t'($urandom);
      valid_in        = 1'b1;
      pxl_in          = data_t'($urandom);
    end
    @(negedge clk);
    valid_weight_in = 1'b0;
    valid_in        = 1'b0;
  endtask

  // Reset, fresh weights, one full image, then drain
  task automatic run_layer(int run);
    @(negedge clk);
    reset       = 1'b1;
    pixels_sent = 0;
    expected_q.delete();
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    load_weights();
    for (int p = 0; p < IMAGE_SIZE; p++) begin
      send_pixel();
    end
    while (expected_q.size() > 0) begin
      @(negedge clk);
    end
    repeat (REPLAY_LEN) @(negedge clk);
    assert (run_outputs == RESULTS_PER_RUN)
      else report_mismatch($sformatf("run %0d gave %0d words, expected %0d",
                                     run, run_outputs, RESULTS_PER_RUN));
  endtask

  initial begin
    void'($urandom(32'h11d6a2b3));
    reset           = 1'b1;
    valid_in        = 1'b0;
    pxl_in          = '0;
    valid_weight_in = 1'b0;
    weight_in       = '0;
    pixels_sent     = 0;
    run_outputs     = 0;
    cycle_count     = 0;
    run_layer(0);
    // Second run shows reset clears the weight index, buffers and read enable
    leave_counters_midway();
    run_layer(1);
    $display("TEST OK");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+tests
src/conv_data_pkg.sv
src/conv_geom_pkg.sv
src/conv_loop_data.sv
src/conv_weight_mac.sv
src/conv_channel_adder.sv
src/conv_align_fifo.sv
src/conv_1x1_layer.sv
tests/conv_1x1_layer_tb.sv

// ==== Bender.yml ====
package:
  name: conv_1x1_layer

sources:
  - files:
      - src/conv_data_pkg.sv
      - src/conv_geom_pkg.sv
      - src/conv_loop_data.sv
      - src/conv_weight_mac.sv
      - src/conv_channel_adder.sv
      - src/conv_align_fifo.sv
      - src/conv_1x1_layer.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/conv_1x1_layer_tb.sv
